/* sources.f */
+incdir+include
verilog/mem_copy_pkg.sv
verilog/copy_ctrl.sv
verilog/load_unit.sv
verilog/word_fifo.sv
verilog/store_unit.sv
verilog/load_store_mixer.sv
verilog/mem_copy_top.sv
tb/tcdm_model.sv
tb/tb_mem_copy.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module tb_mem_copy || exit 1

out=$(./obj_dir/Vtb_mem_copy)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1

/* tb/tb_mem_copy.sv */
`timescale 1ns/1ps
`include "mem_copy_consts.svh"

module tb_mem_copy import mem_copy_pkg::*; ();

  logic               clk_i;
  logic               rst_ni;
  logic               start;
  logic [`ADDR_W-1:0] src_addr;
  logic [`ADDR_W-1:0] dst_addr;
  logic [`CNT_W-1:0]  length;
  logic               busy;
  logic               done;
  mem_req_t           mem_req;
  logic               mem_gnt;
  mem_rsp_t           mem_rsp;
  logic               stall;
  logic               stall_en;
  logic [15:0]        lfsr_q;
  logic [`DATA_W-1:0] image [1024];  // memory as it was before the current copy
  int                 tests_run;
  int                 tests_failed;

  mem_copy_top DUT (
    .clk_i, .rst_ni, .start, .src_addr, .dst_addr, .length, .busy, .done,
    .mem_req, .mem_gnt, .mem_rsp
  );

  tcdm_model MEM (
    .clk_i, .rst_ni, .stall, .req(mem_req), .gnt(mem_gnt), .rsp(mem_rsp),
    .reads(), .writes()
  );

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // expected word at address a after src..src+len-1 went to dst
  function automatic logic [`DATA_W-1:0] ref_word(input int src, input int dst,
                                                  input int len, input int a);
    if (a >= dst && a < dst + len) return image[10'(src + a - dst)];
    return image[10'(a)];
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (stall_en) begin
      lfsr_q = lfsr_next(lfsr_q);  // one bit per stall decision
      stall <= lfsr_q[0];
    end else begin
      stall <= 1'b0;
    end
  end

  task automatic check_words(input string name, input int src, input int dst, input int len,
                             input int lo, input int hi, inout int errs);
    logic [`DATA_W-1:0] exp_w;
    logic [`DATA_W-1:0] got_w;
    for (int a = lo; a <= hi; a++) begin
      exp_w = ref_word(src, dst, len, a);
      got_w = MEM.mem[10'(a)];
      if (got_w !== exp_w) begin
        $display("error %s: addr %0d expected %h actual %h", name, a, exp_w, got_w);
        errs++;
      end
    end
  endtask

  // ign_dst >= 0 adds a second start while the first copy runs
  task automatic copy_test(input string name, input int src, input int dst, input int len,
                           input logic stalls, input int ign_dst);
    int rd0;
    int wr0;
    int cyc;
    int errs;
    errs = 0;
    for (int i = 0; i < 1024; i++) image[10'(i)] = MEM.mem[10'(i)];
    rd0      = MEM.reads;
    wr0      = MEM.writes;
    stall_en = stalls;
    @(posedge clk_i);
    start    <= 1'b1;
    src_addr <= `ADDR_W'(src);
    dst_addr <= `ADDR_W'(dst);
    length   <= `CNT_W'(len);
    @(posedge clk_i);
    start <= 1'b0;
    if (ign_dst >= 0) begin
      cyc = 0;
      do begin
        @(negedge clk_i);
        cyc++;
      end while (!busy && cyc < 20);
      if (!busy) begin
        $display("%s: busy never rose after start", name);
        errs++;
      end
      @(posedge clk_i);
      start    <= 1'b1;
      src_addr <= `ADDR_W'(src + 200);
      dst_addr <= `ADDR_W'(ign_dst);
      @(posedge clk_i);
      start <= 1'b0;
    end
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
    end while (!done && cyc < 4000);
    if (!done) begin
      $display("%s: timed out waiting for done", name);
      errs++;
    end
    if (busy) begin
      $display("%s: busy still high in the done cycle", name);
      errs++;
    end
    stall_en = 1'b0;
    // one word on each side of the region must stay as it was
    check_words(name, src, dst, len, dst - 1, dst + len, errs);
    if (ign_dst >= 0) check_words(name, src, dst, len, ign_dst, ign_dst + len - 1, errs);
    if (MEM.reads - rd0 != len) begin
      $display("error %s: reads expected %0d actual %0d", name, len, MEM.reads - rd0);
      errs++;
    end
    if (MEM.writes - wr0 != len) begin
      $display("error %s: writes expected %0d actual %0d", name, len, MEM.writes - wr0);
      errs++;
    end
    // an ignored start must not come back as a copy once idle
    if (ign_dst >= 0) begin
      for (int i = 0; i < 4; i++) begin
        @(negedge clk_i);
        if (busy) begin
          $display("%s: busy rose again after done", name);
          errs++;
          break;
        end
      end
    end
    tests_run++;
    if (errs == 0) begin
      $display("%s: ok, 0 errors", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED, %0d errors", name, errs);
    end
  endtask

  initial begin
    rst_ni       <= 1'b0;
    start        <= 1'b0;
    src_addr     <= '0;
    dst_addr     <= '0;
    length       <= '0;
    stall_en     = 1'b0;
    lfsr_q       = 16'd28;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    copy_test("single_word", 16, 512, 1, 1'b0, -1);
    copy_test("burst_16", 32, 540, 16, 1'b0, -1);
    copy_test("stall_100", 100, 600, 100, 1'b1, -1);
    copy_test("fifo_depth", 300, 720, `FIFO_DEPTH, 1'b1, -1);
    copy_test("fifo_depth_plus_1", 320, 740, `FIFO_DEPTH + 1, 1'b1, -1);
    copy_test("start_while_busy", 400, 800, 20, 1'b1, 900);
    $display("%0d tests run, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tb/tcdm_model.sv */
`timescale 1ns/1ps
`include "mem_copy_consts.svh"

module tcdm_model import mem_copy_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     stall,   // hold gnt low this cycle
  input  mem_req_t req,
  output logic     gnt,
  output mem_rsp_t rsp,
  output int       reads,
  output int       writes
);

  logic [`DATA_W-1:0] mem [1024];

  assign gnt = !stall;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // every word differs, pattern mixes the full address
      for (int i = 0; i < 1024; i++) begin
        mem[10'(i)] <= 32'(i) * 32'h2545_f491 ^ 32'hc0de_0000 ^ 32'(i);
      end
      rsp    <= '0;
      reads  <= 0;
      writes <= 0;
    end else begin
      rsp.r_valid <= 1'b0;
      if (req.req && gnt) begin
        if (req.wen) begin
          rsp.r_valid <= 1'b1;  // data one cycle after the grant
          rsp.r_data  <= mem[req.add[9:0]];
          reads       <= reads + 1;
        end else begin
          mem[req.add[9:0]] <= req.data;
          writes            <= writes + 1;
        end
      end
    end
  end

endmodule

/* verilog/mem_copy_top.sv */
`timescale 1ns/1ps
`include "mem_copy_consts.svh"

module mem_copy_top import mem_copy_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start,
  input  logic [`ADDR_W-1:0] src_addr,
  input  logic [`ADDR_W-1:0] dst_addr,
  input  logic [`CNT_W-1:0]  length,
  output logic               busy,
  output logic               done,
  output mem_req_t           mem_req,
  input  logic               mem_gnt,
  input  mem_rsp_t           mem_rsp
);

  logic               go;
  logic               clear;
  logic [`ADDR_W-1:0] load_base;
  logic [`ADDR_W-1:0] store_base;
  logic [`CNT_W-1:0]  count;
  logic               store_done;

  mem_req_t           load_req;
  mem_req_t           store_req;
  mem_rsp_t           load_rsp;
  logic               load_gnt;
  logic               store_gnt;

  logic               push;
  logic [`DATA_W-1:0] push_data;
  logic               pop;
  logic [`DATA_W-1:0] pop_data;
  logic               empty;
  logic [`CNT_W-1:0]  fifo_count;

  copy_ctrl u_ctrl (
    .clk_i, .rst_ni, .start, .src_addr, .dst_addr, .length, .store_done,
    .go, .clear, .load_base, .store_base, .count, .busy, .done
  );

  load_unit u_load (
    .clk_i, .rst_ni, .go, .base(load_base), .count, .fifo_count,
    .req(load_req), .gnt(load_gnt), .rsp(load_rsp), .push, .push_data
  );

  word_fifo u_fifo (
    .clk_i, .rst_ni, .clear, .push, .push_data, .pop, .pop_data, .empty, .fifo_count
  );

  store_unit u_store (
    .clk_i, .rst_ni, .go, .base(store_base), .count, .empty, .pop_data, .pop,
    .req(store_req), .gnt(store_gnt), .store_done
  );

  load_store_mixer u_mixer (
    .clk_i, .rst_ni, .clear,
    .load_req, .load_gnt, .load_rsp,
    .store_req, .store_gnt,
    .out_req(mem_req), .out_gnt(mem_gnt), .out_rsp(mem_rsp)
  );

endmodule

/* verilog/load_store_mixer.sv */
`timescale 1ns/1ps

module load_store_mixer import mem_copy_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear,
  input  mem_req_t load_req,
  output logic     load_gnt,
  output mem_rsp_t load_rsp,
  input  mem_req_t store_req,
  output logic     store_gnt,
  output mem_req_t out_req,
  input  logic     out_gnt,
  input  mem_rsp_t out_rsp
);

  localparam logic LOAD  = 1'b0;
  localparam logic STORE = 1'b1;

  logic rr_q;        // channel preferred on a tie
  logic hold_q;      // a request was stalled last cycle
  logic hold_sel_q;  // channel of the stalled request
  logic sel;
  logic xfer;

  // a stalled winner keeps the port so its fields stay steady
  always_comb begin
    if (hold_q)
      sel = hold_sel_q;
    else if (load_req.req && store_req.req)
      sel = rr_q;
    else if (store_req.req)
      sel = STORE;
    else
      sel = LOAD;
  end

  assign out_req = (sel == STORE) ? store_req : load_req;
  assign xfer    = out_req.req && out_gnt;

  assign load_gnt  = xfer && (sel == LOAD);
  assign store_gnt = xfer && (sel == STORE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= LOAD;
      hold_q     <= 1'b0;
      hold_sel_q <= LOAD;
    end else if (clear) begin
      rr_q       <= LOAD;
      hold_q     <= 1'b0;
      hold_sel_q <= LOAD;
    end else begin
      if (xfer) rr_q <= ~rr_q;
      hold_q     <= out_req.req && !out_gnt;
      hold_sel_q <= sel;
    end
  end

  // only reads return data, so any valid response belongs to the load side
  always_comb begin
    if (out_rsp.r_valid)
      load_rsp = out_rsp;
    else
      load_rsp = '0;
  end

endmodule

/* verilog/store_unit.sv */
`timescale 1ns/1ps
`include "mem_copy_consts.svh"

module store_unit import mem_copy_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               go,
  input  logic [`ADDR_W-1:0] base,
  input  logic [`CNT_W-1:0]  count,
  input  logic               empty,
  input  logic [`DATA_W-1:0] pop_data,
  output logic               pop,
  output mem_req_t           req,
  input  logic               gnt,
  output logic               store_done
);

  logic [`ADDR_W-1:0] addr_q;
  logic [`CNT_W-1:0]  left_q;  // words still to write

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      left_q <= '0;
    end else if (go) begin
      addr_q <= base;
      left_q <= count;
    end else if (pop) begin
      addr_q <= addr_q + 1'b1;
      left_q <= left_q - 1'b1;
    end
  end

  // head word stays put until the write is granted
  always_comb begin
    req.req  = (left_q != '0) && !empty;
    req.wen  = 1'b0;
    req.add  = addr_q;
    req.data = pop_data;
  end

  assign pop        = req.req && gnt;
  assign store_done = pop;  // one pulse per granted write

endmodule

/* verilog/word_fifo.sv */
`timescale 1ns/1ps
`include "mem_copy_consts.svh"

module word_fifo (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear,
  input  logic               push,
  input  logic [`DATA_W-1:0] push_data,
  input  logic               pop,
  output logic [`DATA_W-1:0] pop_data,
  output logic               empty,
  output logic [`CNT_W-1:0]  fifo_count
);

  localparam int unsigned PTR_W = $clog2(`FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`FIFO_DEPTH - 1);

  logic [`DATA_W-1:0] mem_q [`FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (fifo_count == `CNT_W'(`FIFO_DEPTH));
  assign empty   = (fifo_count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= push_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_count <= '0;
    end else if (clear) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_count <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop)      fifo_count <= fifo_count + 1'b1;
      else if (!do_push && do_pop) fifo_count <= fifo_count - 1'b1;
    end
  end

  assign pop_data = mem_q[rd_ptr_q];  // head of queue

endmodule

/* verilog/load_unit.sv */
`timescale 1ns/1ps
`include "mem_copy_consts.svh"

module load_unit import mem_copy_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               go,
  input  logic [`ADDR_W-1:0] base,
  input  logic [`CNT_W-1:0]  count,
  input  logic [`CNT_W-1:0]  fifo_count,
  output mem_req_t           req,
  input  logic               gnt,
  input  mem_rsp_t           rsp,
  output logic               push,
  output logic [`DATA_W-1:0] push_data
);

  localparam logic [`CNT_W:0] DEPTH = `FIFO_DEPTH;

  logic [`ADDR_W-1:0] addr_q;
  logic [`CNT_W-1:0]  left_q;        // reads still to issue
  logic [`CNT_W-1:0]  outstanding_q; // granted reads without response
  logic               credit_ok;
  logic               issue;

  // in-flight reads plus buffered words must leave room for one more
  assign credit_ok = ({1'b0, outstanding_q} + {1'b0, fifo_count}) < DEPTH;
  assign issue     = req.req && gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q        <= '0;
      left_q        <= '0;
      outstanding_q <= '0;
    end else if (go) begin
      addr_q        <= base;
      left_q        <= count;
      outstanding_q <= '0;
    end else begin
      if (issue) begin
        addr_q <= addr_q + 1'b1;
        left_q <= left_q - 1'b1;
      end
      if (issue && !rsp.r_valid) outstanding_q <= outstanding_q + 1'b1;
      else if (!issue && rsp.r_valid) outstanding_q <= outstanding_q - 1'b1;
    end
  end

  always_comb begin
    req.req  = (left_q != '0) && credit_ok;
    req.wen  = 1'b1;  // read
    req.add  = addr_q;
    req.data = '0;
  end

  assign push      = rsp.r_valid;  // every response lands in the FIFO
  assign push_data = rsp.r_data;

endmodule

/* verilog/copy_ctrl.sv */
`timescale 1ns/1ps
`include "mem_copy_consts.svh"

module copy_ctrl import mem_copy_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               start,
  input  logic [`ADDR_W-1:0] src_addr,
  input  logic [`ADDR_W-1:0] dst_addr,
  input  logic [`CNT_W-1:0]  length,
  input  logic               store_done,
  output logic               go,
  output logic               clear,
  output logic [`ADDR_W-1:0] load_base,
  output logic [`ADDR_W-1:0] store_base,
  output logic [`CNT_W-1:0]  count,
  output logic               busy,
  output logic               done
);

  copy_state_e       state_q;
  logic [`CNT_W-1:0] stored_q;   // stores completed so far
  logic              last_store;

  assign last_store = store_done && (stored_q == count - 1'b1);

  // setup is captured once per accepted start
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start) begin
      load_base  <= src_addr;
      store_base <= dst_addr;
      count      <= length;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      go       <= 1'b0;
      clear    <= 1'b0;
      stored_q <= '0;
    end else begin
      go    <= 1'b0;  // single cycle pulses
      clear <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            state_q  <= RUN;
            go       <= 1'b1;
            clear    <= 1'b1;
            stored_q <= '0;
          end
        end
        RUN: begin
          if (store_done) begin
            stored_q <= stored_q + 1'b1;
            if (last_store) state_q <= FINISH;
          end
        end
        FINISH:  state_q <= IDLE;  // done shows here
        default: state_q <= IDLE;
      endcase
    end
  end

  assign busy = (state_q == RUN);
  assign done = (state_q == FINISH);

endmodule

/* verilog/mem_copy_pkg.sv */
`include "mem_copy_consts.svh"

package mem_copy_pkg;

  // one access on the shared memory port
  typedef struct packed {
    logic               req;   // request strobe
    logic               wen;   // 1 = read, 0 = write
    logic [`ADDR_W-1:0] add;   // word address
    logic [`DATA_W-1:0] data;  // write data
  } mem_req_t;

  // read response, valid one cycle after a granted read
  typedef struct packed {
    logic               r_valid;
    logic [`DATA_W-1:0] r_data;
  } mem_rsp_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH
  } copy_state_e;

endpackage

/* include/mem_copy_consts.svh */
`ifndef MEM_COPY_CONSTS_SVH
`define MEM_COPY_CONSTS_SVH

// word address width
`define ADDR_W 16

// data word width
`define DATA_W 32

// words buffered between load and store side
`define FIFO_DEPTH 8

// length and count width, lengths 1 to 255
`define CNT_W 8

`endif
